// ==== include/uart_settings.svh ====
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// ##########################################################
// uart loopback build settings
// ##########################################################

// clocks per serial bit, default for tx and rx
`define UART_CYCLES_PER_BIT 3

// idle stop bits after each frame
// gives the receiver time to resync between bytes
`define UART_EXTRA_STOP_BITS 7

// bytes in the fixed message
`define UART_MSG_LEN 16

// width of the running checksum
`define UART_SUM_BITS 32

`endif

// ==== source/uart_line_pkg.sv ====
`default_nettype none

`include "uart_settings.svh"

// types for the serial line side
package uart_line_pkg;

  // start + 8 data + stop + extra stops
  localparam int frame_bits = 10 + `UART_EXTRA_STOP_BITS;

  // cursor must hold the full frame length
  localparam int cursor_bits = $clog2(frame_bits + 1);

  // bit counter, enough for cycles_per_bit up to 65535
  localparam int cycle_bits = 16;

  // one character on the wire
  typedef logic [7:0] data_byte_t;

  // position within a frame
  typedef logic [cursor_bits-1:0] bit_cursor_t;

  // clocks within one bit
  typedef logic [cycle_bits-1:0] bit_cycle_t;

endpackage

`default_nettype wire

// ==== source/uart_msg_pkg.sv ====
`default_nettype none

`include "uart_settings.svh"

// types and text for the message sender
package uart_msg_pkg;

  import uart_line_pkg::*;

  // byte position in the message
  typedef logic [$clog2(`UART_MSG_LEN)-1:0] msg_index_t;

  // running sum of received bytes, wraps
  typedef logic [`UART_SUM_BITS-1:0] checksum_t;

  // ##########################################################
  // fixed message text
  // ##########################################################

  // "Hello, loopback" plus newline
  localparam data_byte_t msg_table [`UART_MSG_LEN] = '{
    "H", "e", "l", "l",
    "o", ",", " ", "l",
    "o", "o", "p", "b",
    "a", "c", "k", 8'h0A
  };

endpackage

`default_nettype wire

// ==== source/uart_tx.sv ====
`default_nettype none

`include "uart_settings.svh"

// serializer, 8N1 plus extra idle stop bits
module uart_tx
  import uart_line_pkg::*;
#(
  parameter int cycles_per_bit = `UART_CYCLES_PER_BIT
) (
  input  wire logic       clock,
  input  wire logic       i_rstn,
  input  wire data_byte_t i_data,
  input  wire logic       i_req,
  output logic            o_serial,
  output logic            o_cts,
  output logic            o_idle
);

  // reload values
  localparam bit_cycle_t  cycle_max   = bit_cycle_t'(cycles_per_bit - 1);
  localparam bit_cursor_t cursor_max  = bit_cursor_t'(frame_bits - 1);
  // cursor at or below this means the stop bit is done
  localparam bit_cursor_t stop_region = bit_cursor_t'(`UART_EXTRA_STOP_BITS);

  bit_cycle_t  cycle;
  bit_cursor_t cursor;
  // bit 0 is the line level, ones shift in from the top
  logic [8:0]  buffer;
  logic        accept;

  // new frame may overlap the extra stop bits
  assign accept = o_cts && i_req;

  // ##########################################################
  // frame sequencing
  // ##########################################################

  always_ff @(posedge clock) begin
    if (!i_rstn) begin
      cycle  <= '0;
      cursor <= '0;
      // line idles high
      buffer <= '1;
    end else if (accept) begin
      // load start bit below the data
      cycle  <= cycle_max;
      cursor <= cursor_max;
      buffer <= {i_data, 1'b0};
    end else if (cycle != '0) begin
      // hold current bit
      cycle <= cycle - 1'b1;
    end else if (cursor != '0) begin
      // next bit, lsb first
      cycle  <= cycle_max;
      cursor <= cursor - 1'b1;
      buffer <= {1'b1, buffer[8:1]};
    end
  end

  // ##########################################################
  // line and status
  // ##########################################################

  assign o_serial = buffer[0];
  // last cycle of the stop bit, or anywhere in the extra stops
  assign o_cts    = ((cursor == stop_region) && (cycle == '0)) ||
                    (cursor < stop_region);
  assign o_idle   = (cursor == '0) && (cycle == '0);

endmodule

`default_nettype wire

// ==== source/uart_rx.sv ====
`default_nettype none

`include "uart_settings.svh"

// deserializer with running checksum
module uart_rx
  import uart_line_pkg::*;
  import uart_msg_pkg::*;
#(
  parameter int cycles_per_bit = `UART_CYCLES_PER_BIT
) (
  input  wire logic  clock,
  input  wire logic  i_rstn,
  input  wire logic  i_serial,
  output data_byte_t o_data,
  output logic       o_valid,
  output checksum_t  o_sum
);

  localparam bit_cycle_t  cycle_max = bit_cycle_t'(cycles_per_bit - 1);
  // wait from start edge to mid start bit
  localparam bit_cycle_t  half_max  =
    bit_cycle_t'((cycles_per_bit > 1) ? (cycles_per_bit / 2 - 1) : 0);
  // start sample, then 8 data, then stop at zero
  localparam bit_cursor_t start_pos = bit_cursor_t'(9);

  logic        active;
  bit_cycle_t  cycle;
  bit_cursor_t cursor;
  logic        sample;
  data_byte_t  shift;
  data_byte_t  data_q;
  logic        valid_q;
  checksum_t   sum_q;

  // mid-bit sample point
  assign sample = active && (cycle == '0);

  // ##########################################################
  // frame tracking
  // ##########################################################

  always_ff @(posedge clock) begin
    if (!i_rstn) begin
      active  <= 1'b0;
      cycle   <= '0;
      cursor  <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (!active) begin
        // hunt for a falling edge
        if (!i_serial) begin
          active <= 1'b1;
          cycle  <= half_max;
          cursor <= start_pos;
        end
      end else if (cycle != '0) begin
        cycle <= cycle - 1'b1;
      end else begin
        cycle <= cycle_max;
        if (cursor != '0) begin
          cursor <= cursor - 1'b1;
          // start bit gone high again, glitch
          if ((cursor == start_pos) && i_serial) begin
            active <= 1'b0;
          end
        end else begin
          // stop sample, low stop drops the frame
          active  <= 1'b0;
          valid_q <= i_serial;
        end
      end
    end
  end

  // data bits, lsb arrives first
  always_ff @(posedge clock) begin
    if (sample && (cursor != '0) && (cursor != start_pos)) begin
      shift <= {i_serial, shift[7:1]};
    end
    if (sample && (cursor == '0)) begin
      data_q <= shift;
    end
  end

  // checksum lags valid by one cycle
  always_ff @(posedge clock) begin
    if (!i_rstn) begin
      sum_q <= '0;
    end else if (valid_q) begin
      sum_q <= sum_q + checksum_t'(data_q);
    end
  end

  assign o_data  = data_q;
  assign o_valid = valid_q;
  assign o_sum   = sum_q;

endmodule

`default_nettype wire

// ==== source/uart_hello.sv ====
`default_nettype none

`include "uart_settings.svh"

// message sender, walks the table one byte per cts
module uart_hello
  import uart_line_pkg::*;
  import uart_msg_pkg::*;
(
  input  wire logic  clock,
  input  wire logic  i_rstn,
  input  wire logic  i_start,
  input  wire logic  i_cts,
  input  wire logic  i_idle,
  output data_byte_t o_data,
  output logic       o_req,
  output logic       o_done
);

  typedef enum logic [1:0] {
    st_waiting,
    st_sending,
    st_draining
  } state_t;

  localparam msg_index_t last_index = msg_index_t'(`UART_MSG_LEN - 1);

  state_t     state;
  msg_index_t index;

  // ##########################################################
  // handshake to transmitter
  // ##########################################################

  // byte under the cursor
  assign o_data = msg_table[index];

  // one strobe per cts cycle
  // cts drops right after, so this is a single pulse
  assign o_req  = (state == st_sending) && i_cts;

  // last frame fully out
  assign o_done = (state == st_draining) && i_idle;

  // ##########################################################
  // sequencing
  // ##########################################################

  always_ff @(posedge clock) begin
    if (!i_rstn) begin
      state <= st_waiting;
      index <= '0;
    end else begin
      case (state)
        st_waiting: begin
          // start pulses only count here
          if (i_start) begin
            state <= st_sending;
            index <= '0;
          end
        end
        st_sending: begin
          if (o_req) begin
            if (index == last_index) begin
              state <= st_draining;
            end else begin
              index <= msg_index_t'(index + 1'b1);
            end
          end
        end
        st_draining: begin
          // tx still busy right after the last req
          if (o_done) begin
            state <= st_waiting;
          end
        end
        default: begin
          state <= st_waiting;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/uart_top.sv ====
`default_nettype none

// sender -> tx -> rx, looped inside
module uart_top
  import uart_line_pkg::*;
  import uart_msg_pkg::*;
(
  input  wire logic  clock,
  input  wire logic  i_rstn,
  input  wire logic  i_start,
  output logic       o_serial,
  output data_byte_t o_data,
  output logic       o_valid,
  output checksum_t  o_sum,
  output logic       o_done
);

  // sender to transmitter
  logic       tx_req;
  data_byte_t tx_data;
  logic       tx_cts;
  logic       tx_idle;

  // the one serial wire
  logic       serial_line;

  // ##########################################################
  // instances
  // ##########################################################

  uart_hello hello (
    .clock   (clock),
    .i_rstn  (i_rstn),
    .i_start (i_start),
    .i_cts   (tx_cts),
    .i_idle  (tx_idle),
    .o_data  (tx_data),
    .o_req   (tx_req),
    .o_done  (o_done)
  );

  uart_tx tx (
    .clock    (clock),
    .i_rstn   (i_rstn),
    .i_data   (tx_data),
    .i_req    (tx_req),
    .o_serial (serial_line),
    .o_cts    (tx_cts),
    .o_idle   (tx_idle)
  );

  // loopback, rx listens to tx
  uart_rx rx (
    .clock    (clock),
    .i_rstn   (i_rstn),
    .i_serial (serial_line),
    .o_data   (o_data),
    .o_valid  (o_valid),
    .o_sum    (o_sum)
  );

  // line also visible outside
  assign o_serial = serial_line;

endmodule

`default_nettype wire

// ==== sim/uart_checker.sv ====
`default_nettype none

`include "uart_settings.svh"

// watches the loopback outputs and scores each test
module uart_checker
  import uart_line_pkg::*;
  import uart_msg_pkg::*;
(
  input  wire logic       clock,
  input  wire logic       i_rstn,
  input  wire logic       i_serial,
  input  wire data_byte_t i_data,
  input  wire logic       i_valid,
  input  wire checksum_t  i_sum,
  input  wire logic       i_done,
  input  wire checksum_t  i_sum_ref,
  output int              o_messages,
  output int              o_tests,
  output int              o_failures,
  output int              o_errors
);

  timeunit 1ns;
  timeprecision 100ps;

  // last byte to done is about 8 bit times, allow a whole frame
  localparam int drain_limit = 17 * `UART_CYCLES_PER_BIT;

  int        index       = 0;
  int        messages    = 0;
  int        tests       = 0;
  int        failures    = 0;
  int        errors      = 0;
  int        errors_mark = 0;
  int        quiet       = 0;
  logic      check_reset = 1'b1;
  // running sum of the table bytes seen so far
  checksum_t sum_model   = '0;

  // wrong value seen on an output
  task automatic report_mismatch(input string what);
    $display("Mismatch at %0d ns: %s", $time, what);
    errors++;
  endtask

  // anything that is not a plain wrong value
  task automatic report_problem(input string what);
    $display("Error at %0d ns: %s", $time, what);
    errors++;
  endtask

  // one verdict line per finished test
  task automatic close_test(input string name);
    tests++;
    if (errors != errors_mark) begin
      failures++;
      $display("test %0d, %s: FAIL", tests, name);
    end else begin
      $display("test %0d, %s: ok", tests, name);
    end
    errors_mark = errors;
  endtask

  // ##########################################################
  // compare on the falling edge, outputs settled
  // ##########################################################

  always @(negedge clock) begin
    if (!i_rstn) begin
      index       = 0;
      messages    = 0;
      quiet       = 0;
      check_reset = 1'b1;
      sum_model   = '0;
    end else begin
      // first cycle out of reset, nothing started yet
      if (check_reset) begin
        if (i_serial !== 1'b1 || i_valid !== 1'b0 || i_done !== 1'b0 || i_sum !== '0) begin
          report_mismatch($sformatf("after reset serial=%b valid=%b done=%b sum=0x%08h",
                                    i_serial, i_valid, i_done, i_sum));
        end
        check_reset = 1'b0;
        close_test("reset state");
      end
      // sum moves only in the cycle after a byte
      if (i_sum !== sum_model) begin
        report_mismatch($sformatf("o_sum is 0x%08h, expected 0x%08h", i_sum, sum_model));
        // resync after a slip
        sum_model = i_sum;
      end
      // bytes in table order
      if (i_valid) begin
        if (index >= `UART_MSG_LEN) begin
          report_problem($sformatf("extra byte 0x%02h arrived after the whole message", i_data));
        end else begin
          if (i_data !== msg_table[index]) begin
            report_mismatch($sformatf("byte %0d is 0x%02h, expected 0x%02h",
                                      index, i_data, msg_table[index]));
          end
          // sum gains the byte that should have come
          sum_model = sum_model + checksum_t'(msg_table[index]);
        end
        index++;
        quiet = 0;
      end
      // done closes a message
      if (i_done) begin
        if (index != `UART_MSG_LEN) begin
          report_mismatch($sformatf("done after %0d bytes, expected %0d", index, `UART_MSG_LEN));
        end
        if (i_sum !== i_sum_ref) begin
          report_mismatch($sformatf("o_sum at done is 0x%08h, expected 0x%08h",
                                    i_sum, i_sum_ref));
        end
        messages++;
        close_test($sformatf("message %0d since reset", messages));
        index = 0;
        quiet = 0;
      end else if (index >= `UART_MSG_LEN) begin
        quiet++;
        if (quiet == drain_limit) begin
          report_problem("no done pulse came after the last byte of the message");
        end
      end
    end
  end

  assign o_messages = messages;
  assign o_tests    = tests;
  assign o_failures = failures;
  assign o_errors   = errors;

endmodule

`default_nettype wire

// ==== sim/uart_tb.sv ====
`default_nettype none

`include "uart_settings.svh"

// loopback testbench, stimulus and summary
module uart_tb
  import uart_line_pkg::*;
  import uart_msg_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // five message lengths of full frames, plus slack
  localparam int timeout_cycles = 5 * `UART_MSG_LEN * 17 * `UART_CYCLES_PER_BIT + 500;
  localparam int random_messages = 4;
  // two reset checks and six messages
  localparam int total_tests = 8;

  logic        clock = 1'b0;
  logic        rstn  = 1'b0;
  logic        start = 1'b0;
  logic        serial;
  data_byte_t  rx_data;
  logic        rx_valid;
  checksum_t   rx_sum;
  logic        done;

  int          messages;
  int          tests;
  int          failures;
  int          errors;
  checksum_t   sum_ref;
  int          cycles = 0;
  logic [31:0] lfsr_state = 32'd66202;

  always #50 clock = ~clock;

  // ##########################################################
  // reference model and random source
  // ##########################################################

  // checksum after n whole messages, wraps at the sum width
  function automatic checksum_t sum_after(input int n);
    logic [63:0] total;
    total = '0;
    for (int i = 0; i < `UART_MSG_LEN; i++) begin
      total = total + 64'(msg_table[i]);
    end
    total = total * 64'(n);
    return checksum_t'(total);
  endfunction

  // galois step, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // one step per bit taken, msb first
  task automatic take_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      value = (value << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // ##########################################################
  // dut and monitor
  // ##########################################################

  uart_top uut (
    .clock    (clock),
    .i_rstn   (rstn),
    .i_start  (start),
    .o_serial (serial),
    .o_data   (rx_data),
    .o_valid  (rx_valid),
    .o_sum    (rx_sum),
    .o_done   (done)
  );

  // expected sum for the message now running
  assign sum_ref = sum_after(messages + 1);

  uart_checker monitor (
    .clock      (clock),
    .i_rstn     (rstn),
    .i_serial   (serial),
    .i_data     (rx_data),
    .i_valid    (rx_valid),
    .i_sum      (rx_sum),
    .i_done     (done),
    .i_sum_ref  (sum_ref),
    .o_messages (messages),
    .o_tests    (tests),
    .o_failures (failures),
    .o_errors   (errors)
  );

  // ##########################################################
  // stimulus
  // ##########################################################

  task automatic apply_reset();
    @(posedge clock);
    rstn  <= 1'b0;
    start <= 1'b0;
    repeat (4) @(posedge clock);
    rstn <= 1'b1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clock);
  endtask

  // start pulse, then wait for done
  // stray starts every 23 cycles when asked
  task automatic run_message(input logic extras);
    int   count;
    logic seen;
    count = 0;
    seen  = 1'b0;
    @(posedge clock);
    start <= 1'b1;
    while (!seen) begin
      @(posedge clock);
      count++;
      start <= extras && (count % 23 == 0);
      @(negedge clock);
      seen = done;
    end
    @(posedge clock);
    start <= 1'b0;
  endtask

  initial begin
    int gap;
    int extra_bit;
    apply_reset();
    idle_cycles(3);
    // one clean message
    run_message(1'b0);
    // random gaps, first of these always pokes start
    for (int m = 0; m < random_messages; m++) begin
      take_bits(6, gap);
      take_bits(1, extra_bit);
      idle_cycles(gap);
      run_message((extra_bit != 0) || (m == 0));
    end
    // sum must restart from zero
    idle_cycles(5);
    apply_reset();
    idle_cycles(3);
    run_message(1'b0);
    idle_cycles(10);
    if (tests != total_tests) begin
      $display("Error: expected %0d tests to finish, only %0d did", total_tests, tests);
    end
    $display("summary: %0d tests, %0d failed, %0d errors", tests, failures, errors);
    if (failures == 0 && errors == 0 && tests == total_tests) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // hang guard
  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Timeout: run still going after %0d cycles, a done pulse went missing", cycles);
      $display("Test failures found");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
source/uart_line_pkg.sv
source/uart_msg_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_hello.sv
source/uart_top.sv
sim/uart_checker.sv
sim/uart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the uart loopback testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  -f project.f \
  --top-module uart_tb \
  -o uart_sim

# keep the log for the verdict
./obj_dir/uart_sim > sim.log
cat sim.log

if grep -q "Test failures found" sim.log; then
  echo "simulation reported failures"
  exit 1
fi

echo "simulation clean"
exit 0
